//--- tb.f
src/simd_pkg.sv
src/simd_decode.sv
src/simd_lane_adder.sv
src/simd_compare.sv
src/simd_shifter.sv
src/simd_permute.sv
src/simd_alu.sv
dv/simd_alu_checker.sv
dv/tb_simd_alu.sv

//--- run.sh
#!/bin/sh
# Build and run the simd_alu testbench with Verilator
verilator --binary --timing --assert -f tb.f --top-module tb_simd_alu -o sim_simd_alu \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_simd_alu > sim.log 2>&1 ; cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- dv/tb_simd_alu.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Testbench for simd_alu with directed bursts, then random requests
// Stimulus changes on the rising edge; the checker compares results
//////////////////////////////////////////////////////////////////////
module tb_simd_alu;

  logic                clk;
  logic                reset;
  logic                enable;
  simd_pkg::simd_req_t req;
  logic [31:0]         result;
  logic                ov;
  logic                valid;
  int                  errors;
  int                  checks;
  int                  issued;
  int                  timeouts;
  int                  wait_cycles;
  simd_pkg::simd_op_e  op;
  logic [31:0]         word;
  logic [31:0]         boundary [0:7];

  simd_alu dut_i (
    .clk_i    (clk),
    .reset_i  (reset),
    .enable_i (enable),
    .req_i    (req),
    .result_o (result),
    .ov_o     (ov),
    .valid_o  (valid)
  );

  simd_alu_checker checker_i (
    .clk_i    (clk),
    .reset_i  (reset),
    .enable_i (enable),
    .req_i    (req),
    .result_i (result),
    .ov_i     (ov),
    .valid_i  (valid),
    .errors_o (errors),
    .checks_o (checks)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Lane-boundary words a quarter of the time
  function automatic logic [31:0] rand_word();
    if ($urandom_range(3, 0) == 0) begin
      return boundary[3'($urandom_range(7, 0))];
    end
    return $urandom();
  endfunction

  task automatic send_op(input simd_pkg::simd_op_e o, input logic [31:0] a,
                         input logic [31:0] b, input logic [31:0] rd, input logic [4:0] imm);
    @(posedge clk);
    enable <= 1'b1;
    req    <= '{op: o, a: a, b: b, rd: rd, imm: imm};
    issued++;
  endtask

  // Operands keep changing so a held result is visible
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      enable <= 1'b0;
      req.a  <= $urandom();
    end
  endtask

  initial begin
    reset    = 1'b1;
    enable   = 1'b0;
    req      = '0;
    issued   = 0;
    timeouts = 0;
    boundary = '{32'h7f7f7f7f, 32'h80808080, 32'hffffffff, 32'h00000000,
                 32'h7fff7fff, 32'h80008000, 32'h01010101, 32'h7fff8000};
    void'($urandom(32'h766a72f2));
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    idle_cycles(4);

    // Adder ops across lane boundaries, back to back
    for (int n = 0; n <= int'(simd_pkg::OP_UKSUB16); n++) begin
      op = simd_pkg::simd_op_e'(7'(n));
      for (int i = 0; i < 8; i++) begin
        for (int k = 0; k < 4; k++) begin
          send_op(op, boundary[3'(i)], boundary[3'((i + k) % 8)], $urandom(), 5'($urandom()));
        end
      end
    end
    idle_cycles(2);

    // Compares and min/max with equal operands
    for (int n = int'(simd_pkg::OP_CMPEQ8); n <= int'(simd_pkg::OP_UMAX16); n++) begin
      op = simd_pkg::simd_op_e'(7'(n));
      repeat (10) begin
        word = rand_word();
        send_op(op, word, word, $urandom(), 5'($urandom()));
      end
    end
    idle_cycles(3);

    // Every shift amount, including those past the lane width
    for (int n = int'(simd_pkg::OP_SRA8); n <= int'(simd_pkg::OP_SLLI16); n++) begin
      op = simd_pkg::simd_op_e'(7'(n));
      for (int amt = 0; amt < 32; amt++) begin
        send_op(op, rand_word(), ($urandom() & ~32'h1f) | 32'(amt), $urandom(), 5'(amt));
      end
    end

    // Random mix of legal opcodes with random enable gaps
    repeat (800) begin
      op = simd_pkg::simd_op_e'(7'($urandom_range(int'(simd_pkg::OP_INSB3), 0)));
      send_op(op, rand_word(), rand_word(), $urandom(), 5'($urandom()));
      if ($urandom_range(7, 0) == 0) begin
        idle_cycles($urandom_range(3, 1));
      end
    end
    idle_cycles(1);

    wait_cycles = 0;
    while (checks < issued && wait_cycles < 20) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (checks < issued) begin
      timeouts++;
      $display("Timeout: only %0d of %0d results were checked", checks, issued);
    end
    idle_cycles(2);
    // Counts from the last edge settle before the summary
    @(negedge clk);

    $display("Summary: %0d requests, %0d results checked, %0d mismatches, %0d timeouts",
             issued, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- dv/simd_alu_checker.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Reference model and output checks for simd_alu
// Samples at the rising edge, before the DUT updates its registers
// Comparisons start on the first edge after reset is released
//////////////////////////////////////////////////////////////////////
module simd_alu_checker (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      enable_i,
  input  simd_pkg::simd_req_t       req_i,
  input  logic [simd_pkg::XLEN-1:0] result_i,
  input  logic                      ov_i,
  input  logic                      valid_i,
  output int                        errors_o,
  output int                        checks_o
);

  logic               seen_reset = 1'b0;
  logic               exp_valid;
  logic [31:0]        exp_result;
  logic               exp_ov;
  string              exp_name;
  int                 err_cnt = 0;
  int                 chk_cnt = 0;
  logic [31:0]        model_res;
  logic               model_ov;
  simd_pkg::simd_op_e cur_op;

  function automatic longint clamp_to(input longint v, input longint lo, input longint hi,
                                      output logic hit);
    hit = (v < lo) || (v > hi);
    if (v < lo) begin
      return lo;
    end
    if (v > hi) begin
      return hi;
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // One lane of the adder, compare and shift ops
  //////////////////////////////////////////////////////////////////////
  function automatic longint lane_model(input simd_pkg::simd_op_e op, input int w,
                                        input longint ua, input longint ub, input int amt,
                                        output logic clamp);
    longint half;
    longint umax;
    longint sa;
    longint sb;
    longint x;
    half  = longint'(1) << (w - 1);
    umax  = (longint'(1) << w) - 1;
    sa    = (ua >= half) ? ua - (umax + 1) : ua;
    sb    = (ub >= half) ? ub - (umax + 1) : ub;
    clamp = 1'b0;
    x     = longint'(0);
    case (op)
      simd_pkg::OP_ADD8,    simd_pkg::OP_ADD16:    x = ua + ub;
      simd_pkg::OP_SUB8,    simd_pkg::OP_SUB16:    x = ua - ub;
      // Floor of the exact half
      simd_pkg::OP_RADD8,   simd_pkg::OP_RADD16:   x = (sa + sb) >>> 1;
      simd_pkg::OP_URADD8,  simd_pkg::OP_URADD16:  x = (ua + ub) >>> 1;
      simd_pkg::OP_RSUB8,   simd_pkg::OP_RSUB16:   x = (sa - sb) >>> 1;
      simd_pkg::OP_URSUB8,  simd_pkg::OP_URSUB16:  x = (ua - ub) >>> 1;
      simd_pkg::OP_KADD8,   simd_pkg::OP_KADD16:   x = clamp_to(sa + sb, -half, half - 1, clamp);
      simd_pkg::OP_UKADD8,  simd_pkg::OP_UKADD16:  x = clamp_to(ua + ub, 0, umax, clamp);
      simd_pkg::OP_KSUB8,   simd_pkg::OP_KSUB16:   x = clamp_to(sa - sb, -half, half - 1, clamp);
      simd_pkg::OP_UKSUB8,  simd_pkg::OP_UKSUB16:  x = clamp_to(ua - ub, 0, umax, clamp);
      simd_pkg::OP_CMPEQ8,  simd_pkg::OP_CMPEQ16:  x = (ua == ub) ? umax : longint'(0);
      simd_pkg::OP_SCMPLT8, simd_pkg::OP_SCMPLT16: x = (sa < sb) ? umax : longint'(0);
      simd_pkg::OP_SCMPLE8, simd_pkg::OP_SCMPLE16: x = (sa <= sb) ? umax : longint'(0);
      simd_pkg::OP_UCMPLT8, simd_pkg::OP_UCMPLT16: x = (ua < ub) ? umax : longint'(0);
      simd_pkg::OP_UCMPLE8, simd_pkg::OP_UCMPLE16: x = (ua <= ub) ? umax : longint'(0);
      simd_pkg::OP_SMIN8,   simd_pkg::OP_SMIN16:   x = (sa < sb) ? ua : ub;
      simd_pkg::OP_SMAX8,   simd_pkg::OP_SMAX16:   x = (sa > sb) ? ua : ub;
      simd_pkg::OP_UMIN8,   simd_pkg::OP_UMIN16:   x = (ua < ub) ? ua : ub;
      simd_pkg::OP_UMAX8,   simd_pkg::OP_UMAX16:   x = (ua > ub) ? ua : ub;
      simd_pkg::OP_SRA8,    simd_pkg::OP_SRA16,
      simd_pkg::OP_SRAI8,   simd_pkg::OP_SRAI16:   x = sa >>> amt;
      simd_pkg::OP_SRL8,    simd_pkg::OP_SRL16,
      simd_pkg::OP_SRLI8,   simd_pkg::OP_SRLI16:   x = ua >> amt;
      simd_pkg::OP_SLL8,    simd_pkg::OP_SLL16,
      simd_pkg::OP_SLLI8,   simd_pkg::OP_SLLI16:   x = ua << amt;
      default:                                     x = longint'(0);
    endcase
    return x & umax;
  endfunction

  // Byte placement of unpack, pack and insert byte
  function automatic logic [31:0] permute_model(input simd_pkg::simd_op_e op,
                                                input logic [31:0] a, input logic [31:0] b,
                                                input logic [31:0] rd);
    logic [31:0] r;
    logic [7:0]  bh;
    logic [7:0]  bl;
    int          hi;
    int          lo;
    logic        sgn;
    r   = rd;
    hi  = 0;
    lo  = 0;
    sgn = op inside {simd_pkg::OP_SUNPKD810, simd_pkg::OP_SUNPKD820, simd_pkg::OP_SUNPKD830,
                     simd_pkg::OP_SUNPKD831, simd_pkg::OP_SUNPKD832};
    case (op)
      simd_pkg::OP_SUNPKD810, simd_pkg::OP_ZUNPKD810: begin hi = 1; lo = 0; end
      simd_pkg::OP_SUNPKD820, simd_pkg::OP_ZUNPKD820: begin hi = 2; lo = 0; end
      simd_pkg::OP_SUNPKD830, simd_pkg::OP_ZUNPKD830: begin hi = 3; lo = 0; end
      simd_pkg::OP_SUNPKD831, simd_pkg::OP_ZUNPKD831: begin hi = 3; lo = 1; end
      simd_pkg::OP_SUNPKD832, simd_pkg::OP_ZUNPKD832: begin hi = 3; lo = 2; end
      simd_pkg::OP_PKBB16: return {a[15:0], b[15:0]};
      simd_pkg::OP_PKBT16: return {a[15:0], b[31:16]};
      simd_pkg::OP_PKTB16: return {a[31:16], b[15:0]};
      simd_pkg::OP_PKTT16: return {a[31:16], b[31:16]};
      simd_pkg::OP_INSB0:  begin r[7:0] = a[7:0]; return r; end
      simd_pkg::OP_INSB1:  begin r[15:8] = a[7:0]; return r; end
      simd_pkg::OP_INSB2:  begin r[23:16] = a[7:0]; return r; end
      simd_pkg::OP_INSB3:  begin r[31:24] = a[7:0]; return r; end
      default: return 32'h0;
    endcase
    bh = 8'(a >> (8 * hi));
    bl = 8'(a >> (8 * lo));
    return {{8{sgn & bh[7]}}, bh, {8{sgn & bl[7]}}, bl};
  endfunction

  function automatic void model_op(input simd_pkg::simd_req_t req, output logic [31:0] res,
                                   output logic ov);
    simd_pkg::simd_op_e op;
    string              nm;
    int                 w;
    int                 amt;
    longint             mask;
    longint             acc;
    longint             x;
    logic               hit;
    op  = req.op;
    nm  = op.name();
    ov  = 1'b0;
    acc = longint'(0);
    if (op inside {[simd_pkg::OP_SUNPKD810 : simd_pkg::OP_INSB3]}) begin
      res = permute_model(op, req.a, req.b, req.rd);
    end else begin
      // Names ending in 16 work on halfword lanes
      w    = (nm.substr(nm.len() - 2, nm.len() - 1) == "16") ? 16 : 8;
      mask = (longint'(1) << w) - 1;
      if (op inside {simd_pkg::OP_SRAI8, simd_pkg::OP_SRAI16, simd_pkg::OP_SRLI8,
                     simd_pkg::OP_SRLI16, simd_pkg::OP_SLLI8, simd_pkg::OP_SLLI16}) begin
        amt = int'(req.imm) & (w - 1);
      end else begin
        amt = int'(req.b[4:0]) & (w - 1);
      end
      for (int l = 0; l < 32 / w; l++) begin
        x   = lane_model(op, w, longint'(req.a >> (w * l)) & mask,
                         longint'(req.b >> (w * l)) & mask, amt, hit);
        ov  = ov | hit;
        acc = acc | (x << (w * l));
      end
      res = 32'(acc);
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare last cycle's expectation, then model this cycle's request
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk_i) begin
    if (reset_i) begin
      seen_reset = 1'b1;
      exp_valid  = 1'b0;
      exp_result = '0;
      exp_ov     = 1'b0;
      exp_name   = "reset";
    end else if (seen_reset) begin
      if (valid_i !== exp_valid) begin
        err_cnt++;
        $display("mismatch %s valid_o: expected %0b, actual %0b at %0t",
                 exp_name, exp_valid, valid_i, $time);
      end
      if (result_i !== exp_result) begin
        err_cnt++;
        $display("mismatch %s result_o: expected %h, actual %h at %0t",
                 exp_name, exp_result, result_i, $time);
      end
      if (ov_i !== exp_ov) begin
        err_cnt++;
        $display("mismatch %s ov_o: expected %0b, actual %0b at %0t",
                 exp_name, exp_ov, ov_i, $time);
      end
      if (exp_valid) begin
        chk_cnt++;
      end
      exp_valid = enable_i;
      if (enable_i) begin
        model_op(req_i, model_res, model_ov);
        exp_result = model_res;
        exp_ov     = model_ov;
        cur_op     = req_i.op;
        exp_name   = cur_op.name();
      end else begin
        // Result and flag hold their last values
        exp_name = "idle hold";
      end
    end
    errors_o <= err_cnt;
    checks_o <= chk_cnt;
  end

endmodule

//--- src/simd_alu.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Registered packed-SIMD ALU with a fixed latency of one cycle
// No back-pressure. A result is lost unless taken while valid_o is high
//////////////////////////////////////////////////////////////////////
module simd_alu (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      enable_i,
  input  simd_pkg::simd_req_t       req_i,
  output logic [simd_pkg::XLEN-1:0] result_o,
  output logic                      ov_o,
  output logic                      valid_o
);

  simd_pkg::simd_ctrl_t      ctrl;
  simd_pkg::simd_lane_sum_t  lane_sum;
  logic [simd_pkg::XLEN-1:0] add_res;
  logic [simd_pkg::XLEN-1:0] cmp_res;
  logic [simd_pkg::XLEN-1:0] minmax_res;
  logic [simd_pkg::XLEN-1:0] shift_res;
  logic [simd_pkg::XLEN-1:0] perm_res;
  logic [simd_pkg::XLEN-1:0] res_d;
  logic                      add_ov;

  simd_decode u_decode (
    .op_i   (req_i.op),
    .ctrl_o (ctrl)
  );

  simd_lane_adder u_adder (
    .ctrl_i   (ctrl),
    .a_i      (req_i.a),
    .b_i      (req_i.b),
    .sum_o    (lane_sum),
    .result_o (add_res),
    .ov_o     (add_ov)
  );

  simd_compare u_compare (
    .ctrl_i          (ctrl),
    .a_i             (req_i.a),
    .b_i             (req_i.b),
    .sum_i           (lane_sum),
    .cmp_result_o    (cmp_res),
    .minmax_result_o (minmax_res)
  );

  simd_shifter u_shifter (
    .ctrl_i   (ctrl),
    .a_i      (req_i.a),
    .b_amt_i  (req_i.b[4:0]),
    .imm_i    (req_i.imm),
    .result_o (shift_res)
  );

  simd_permute u_permute (
    .op_i     (req_i.op),
    .a_i      (req_i.a),
    .b_i      (req_i.b),
    .rd_i     (req_i.rd),
    .result_o (perm_res)
  );

  ////////////////////////////////////////////////////////////////////
  // Result mux and output register
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (ctrl.unit)
      simd_pkg::UNIT_ADDER:   res_d = add_res;
      simd_pkg::UNIT_COMPARE: res_d = cmp_res;
      simd_pkg::UNIT_MINMAX:  res_d = minmax_res;
      simd_pkg::UNIT_SHIFT:   res_d = shift_res;
      simd_pkg::UNIT_PERMUTE: res_d = perm_res;
      default:                res_d = '0;
    endcase
  end

  // Result and flag hold while idle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o  <= 1'b0;
      ov_o     <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= enable_i;
      if (enable_i) begin
        result_o <= res_d;
        ov_o     <= add_ov;
      end
    end
  end

  // Only saturating requests may raise the clamp flag
  a_ov_source: assert property (@(posedge clk_i) disable iff (reset_i)
    (enable_i && !ctrl.saturate) |=> !ov_o)
    else $error("simd_alu: ov_o set after a request that does not saturate");

  // Equal operands always compare equal through the shared subtraction
  a_eq_self: assert property (@(posedge clk_i) disable iff (reset_i)
    (enable_i && ctrl.unit == simd_pkg::UNIT_COMPARE && ctrl.cmp == simd_pkg::CMP_EQ &&
     req_i.a == req_i.b) |=> (result_o == '1))
    else $error("simd_alu: equal operands did not compare equal");

endmodule

//--- src/simd_permute.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Byte unpack, halfword pack and insert byte, chosen by opcode
//////////////////////////////////////////////////////////////////////
module simd_permute (
  input  simd_pkg::simd_op_e        op_i,
  input  logic [simd_pkg::XLEN-1:0] a_i,
  input  logic [simd_pkg::XLEN-1:0] b_i,
  input  logic [simd_pkg::XLEN-1:0] rd_i,
  output logic [simd_pkg::XLEN-1:0] result_o
);

  logic [3:0][7:0] ab;

  // Two bytes into two halfwords, optionally sign extended
  function automatic logic [simd_pkg::XLEN-1:0] unpack(input logic [7:0] hi,
                                                       input logic [7:0] lo,
                                                       input logic       sgn);
    return {{8{sgn & hi[7]}}, hi, {8{sgn & lo[7]}}, lo};
  endfunction

  assign ab = a_i;

  always_comb begin
    unique case (op_i)
      simd_pkg::OP_SUNPKD810: result_o = unpack(ab[1], ab[0], 1'b1);
      simd_pkg::OP_SUNPKD820: result_o = unpack(ab[2], ab[0], 1'b1);
      simd_pkg::OP_SUNPKD830: result_o = unpack(ab[3], ab[0], 1'b1);
      simd_pkg::OP_SUNPKD831: result_o = unpack(ab[3], ab[1], 1'b1);
      simd_pkg::OP_SUNPKD832: result_o = unpack(ab[3], ab[2], 1'b1);
      simd_pkg::OP_ZUNPKD810: result_o = unpack(ab[1], ab[0], 1'b0);
      simd_pkg::OP_ZUNPKD820: result_o = unpack(ab[2], ab[0], 1'b0);
      simd_pkg::OP_ZUNPKD830: result_o = unpack(ab[3], ab[0], 1'b0);
      simd_pkg::OP_ZUNPKD831: result_o = unpack(ab[3], ab[1], 1'b0);
      simd_pkg::OP_ZUNPKD832: result_o = unpack(ab[3], ab[2], 1'b0);
      // Half of a on top, half of b below
      simd_pkg::OP_PKBB16:    result_o = {a_i[15:0],  b_i[15:0]};
      simd_pkg::OP_PKBT16:    result_o = {a_i[15:0],  b_i[31:16]};
      simd_pkg::OP_PKTB16:    result_o = {a_i[31:16], b_i[15:0]};
      simd_pkg::OP_PKTT16:    result_o = {a_i[31:16], b_i[31:16]};
      simd_pkg::OP_INSB0:     result_o = {rd_i[31:8], ab[0]};
      simd_pkg::OP_INSB1:     result_o = {rd_i[31:16], ab[0], rd_i[7:0]};
      simd_pkg::OP_INSB2:     result_o = {rd_i[31:24], ab[0], rd_i[15:0]};
      simd_pkg::OP_INSB3:     result_o = {ab[0], rd_i[23:0]};
      default:                result_o = '0;
    endcase
  end

endmodule

//--- src/simd_shifter.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Lane shifter built from right shifters only
// Amount is masked to 3 bits for byte lanes and 4 bits for halfwords
//////////////////////////////////////////////////////////////////////
module simd_shifter (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] a_i,
  input  logic [4:0]                b_amt_i,
  input  logic [4:0]                imm_i,
  output logic [simd_pkg::XLEN-1:0] result_o
);

  logic                      w8;
  logic [3:0]                amt;
  logic [simd_pkg::XLEN-1:0] src;
  logic [simd_pkg::XLEN-1:0] byte_sh;
  logic [simd_pkg::XLEN-1:0] half_sh;
  logic [simd_pkg::XLEN-1:0] shifted;

  function automatic logic [simd_pkg::XLEN-1:0] bit_rev(input logic [simd_pkg::XLEN-1:0] v);
    logic [simd_pkg::XLEN-1:0] rev;
    for (int i = 0; i < simd_pkg::XLEN; i++) begin
      rev[i] = v[simd_pkg::XLEN-1-i];
    end
    return rev;
  endfunction

  assign w8  = (ctrl_i.width == simd_pkg::W8);
  assign amt = ctrl_i.use_imm ? imm_i[3:0] : b_amt_i[3:0];

  // Left shift is a right shift of the reversed word
  assign src = ctrl_i.shift_left ? bit_rev(a_i) : a_i;

  always_comb begin
    logic fill;
    for (int i = 0; i < 4; i++) begin
      fill = ctrl_i.shift_arith & src[8*i+7];
      byte_sh[8*i +: 8] = 8'($signed({fill, src[8*i +: 8]}) >>> amt[2:0]);
    end
    for (int j = 0; j < 2; j++) begin
      fill = ctrl_i.shift_arith & src[16*j+15];
      half_sh[16*j +: 16] = 16'($signed({fill, src[16*j +: 16]}) >>> amt);
    end
  end

  assign shifted  = w8 ? byte_sh : half_sh;
  assign result_o = ctrl_i.shift_left ? bit_rev(shifted) : shifted;

endmodule

//--- src/simd_compare.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Lane compares and min/max from the adder's a - b
// Expects ctrl_i.sub set so that sum_i holds the difference
//////////////////////////////////////////////////////////////////////
module simd_compare (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] a_i,
  input  logic [simd_pkg::XLEN-1:0] b_i,
  input  simd_pkg::simd_lane_sum_t  sum_i,
  output logic [simd_pkg::XLEN-1:0] cmp_result_o,
  output logic [simd_pkg::XLEN-1:0] minmax_result_o
);

  logic       w8;
  logic [3:0] byte_zero;
  logic [3:0] byte_lt;
  logic [3:0] lane_eq;
  logic [3:0] lane_lt;
  logic [3:0] pick_a;

  assign w8 = (ctrl_i.width == simd_pkg::W8);

  // Less-than is the sign of the exact a - b
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      byte_zero[i] = (sum_i.lane[i][7:0] == 8'h00);
      byte_lt[i]   = sum_i.lane[i][8] ^
                     (ctrl_i.is_signed ? (a_i[8*i+7] ^ ~b_i[8*i+7]) : 1'b1);
    end
  end

  // Merge byte flags into halfword lanes
  assign lane_eq = w8 ? byte_zero : {{2{&byte_zero[3:2]}}, {2{&byte_zero[1:0]}}};
  assign lane_lt = w8 ? byte_lt   : {{2{byte_lt[3]}}, {2{byte_lt[1]}}};

  always_comb begin
    unique case (ctrl_i.cmp)
      simd_pkg::CMP_LT,
      simd_pkg::CMP_MIN: pick_a = lane_lt;
      simd_pkg::CMP_LE:  pick_a = lane_lt | lane_eq;
      simd_pkg::CMP_MAX: pick_a = ~(lane_lt | lane_eq);
      default:           pick_a = lane_eq;
    endcase
  end

  // Widen to byte masks and select a or b per byte
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      cmp_result_o[8*i +: 8]    = {8{pick_a[i]}};
      minmax_result_o[8*i +: 8] = pick_a[i] ? a_i[8*i +: 8] : b_i[8*i +: 8];
    end
  end

endmodule

//--- src/simd_lane_adder.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Lane-split adder for 8-bit and 16-bit lanes
// Halving results round toward minus infinity
// ov_o reports clamping only when saturate is set
//////////////////////////////////////////////////////////////////////
module simd_lane_adder (
  input  simd_pkg::simd_ctrl_t      ctrl_i,
  input  logic [simd_pkg::XLEN-1:0] a_i,
  input  logic [simd_pkg::XLEN-1:0] b_i,
  output simd_pkg::simd_lane_sum_t  sum_o,
  output logic [simd_pkg::XLEN-1:0] result_o,
  output logic                      ov_o
);

  logic                      w8;
  logic [simd_pkg::XLEN-1:0] b_op;
  logic [3:0][8:0]           r;
  logic [3:0]                top;        // Bit 8 of the exact byte-slice sum
  logic [3:0]                ovf;
  logic [3:0]                lane_top;
  logic [3:0]                lane_ovf;
  logic [simd_pkg::XLEN-1:0] wrap_res;
  logic [simd_pkg::XLEN-1:0] half_res;
  logic [simd_pkg::XLEN-1:0] sat_res;

  assign w8   = (ctrl_i.width == simd_pkg::W8);
  assign b_op = ctrl_i.sub ? ~b_i : b_i;

  //////////////////////////////////////////////////////////////////////
  // Byte adders
  //////////////////////////////////////////////////////////////////////

  // Carry runs inside a halfword lane and breaks at every lane start
  always_comb begin
    logic carry;
    logic cin;
    carry = 1'b0;
    for (int i = 0; i < 4; i++) begin
      cin   = (w8 || (i % 2 == 0)) ? ctrl_i.sub : carry;
      r[i]  = {1'b0, a_i[8*i +: 8]} + {1'b0, b_op[8*i +: 8]} + {8'd0, cin};
      carry = r[i][8];
    end
  end

  assign sum_o.lane = r;

  // Extension bits of both operands plus carry give the exact top bit
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      top[i] = r[i][8] ^ (ctrl_i.is_signed ? (a_i[8*i+7] ^ b_op[8*i+7]) : ctrl_i.sub);
      ovf[i] = ctrl_i.is_signed ? (top[i] ^ r[i][7]) : top[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Wrapped, halving and saturating results
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    logic msb_byte;
    for (int i = 0; i < 4; i++) begin
      msb_byte    = w8 || (i % 2 == 1);
      // Halfword lanes take their flags from the upper byte
      lane_top[i] = w8 ? top[i] : top[i | 1];
      lane_ovf[i] = w8 ? ovf[i] : ovf[i | 1];

      wrap_res[8*i +: 8] = r[i][7:0];
      half_res[8*i +: 8] = {msb_byte ? lane_top[i] : r[i | 1][0], r[i][7:1]};

      if (!lane_ovf[i]) begin
        sat_res[8*i +: 8] = r[i][7:0];
      end else if (ctrl_i.is_signed) begin
        // Lane minimum when the exact result is negative, else maximum
        sat_res[8*i +: 8] = {~(lane_top[i] ^ msb_byte), {7{~lane_top[i]}}};
      end else begin
        sat_res[8*i +: 8] = {8{~ctrl_i.sub}};
      end
    end
  end

  always_comb begin
    if (ctrl_i.halve) begin
      result_o = half_res;
    end else if (ctrl_i.saturate) begin
      result_o = sat_res;
    end else begin
      result_o = wrap_res;
    end
  end

  assign ov_o = ctrl_i.saturate & (|lane_ovf);

  // A clamped lane never equals its wrapped sum
  always_comb begin
    if (ov_o) begin
      assert (ctrl_i.unit == simd_pkg::UNIT_ADDER && sat_res != wrap_res)
        else $error("simd_lane_adder: ov_o set without a clamped lane in an adder op");
    end
  end

endmodule

//--- src/simd_decode.sv
`timescale 1ns/1ps
//////////////////////////////////////////////////////////////////////
// Opcode decoder, purely combinational
// Codes past OP_INSB3 decode to no unit and give a zero result
//////////////////////////////////////////////////////////////////////
module simd_decode (
  input  simd_pkg::simd_op_e   op_i,
  output simd_pkg::simd_ctrl_t ctrl_o
);

  always_comb begin
    ctrl_o = '0;
    // Odd codes are the 16-bit forms
    ctrl_o.width = simd_pkg::simd_width_e'(op_i[0]);

    // Unit from the opcode group
    if (op_i <= simd_pkg::OP_UKSUB16) begin
      ctrl_o.unit = simd_pkg::UNIT_ADDER;
    end else if (op_i <= simd_pkg::OP_UCMPLE16) begin
      ctrl_o.unit = simd_pkg::UNIT_COMPARE;
    end else if (op_i <= simd_pkg::OP_UMAX16) begin
      ctrl_o.unit = simd_pkg::UNIT_MINMAX;
    end else if (op_i <= simd_pkg::OP_SLLI16) begin
      ctrl_o.unit = simd_pkg::UNIT_SHIFT;
    end else if (op_i <= simd_pkg::OP_INSB3) begin
      ctrl_o.unit = simd_pkg::UNIT_PERMUTE;
    end else begin
      ctrl_o.unit = simd_pkg::simd_unit_e'(3'b111);
    end

    // Compare and min/max reuse the subtraction
    ctrl_o.sub = (ctrl_o.unit inside {simd_pkg::UNIT_COMPARE, simd_pkg::UNIT_MINMAX}) ||
                 (op_i inside {simd_pkg::OP_SUB8,   simd_pkg::OP_SUB16,
                               simd_pkg::OP_RSUB8,  simd_pkg::OP_RSUB16,
                               simd_pkg::OP_URSUB8, simd_pkg::OP_URSUB16,
                               simd_pkg::OP_KSUB8,  simd_pkg::OP_KSUB16,
                               simd_pkg::OP_UKSUB8, simd_pkg::OP_UKSUB16});

    ctrl_o.is_signed = op_i inside {simd_pkg::OP_RADD8,   simd_pkg::OP_RADD16,
                                    simd_pkg::OP_RSUB8,   simd_pkg::OP_RSUB16,
                                    simd_pkg::OP_KADD8,   simd_pkg::OP_KADD16,
                                    simd_pkg::OP_KSUB8,   simd_pkg::OP_KSUB16,
                                    simd_pkg::OP_SCMPLT8, simd_pkg::OP_SCMPLT16,
                                    simd_pkg::OP_SCMPLE8, simd_pkg::OP_SCMPLE16,
                                    simd_pkg::OP_SMIN8,   simd_pkg::OP_SMIN16,
                                    simd_pkg::OP_SMAX8,   simd_pkg::OP_SMAX16};

    ctrl_o.halve = op_i inside {simd_pkg::OP_RADD8,  simd_pkg::OP_RADD16,
                                simd_pkg::OP_URADD8, simd_pkg::OP_URADD16,
                                simd_pkg::OP_RSUB8,  simd_pkg::OP_RSUB16,
                                simd_pkg::OP_URSUB8, simd_pkg::OP_URSUB16};

    ctrl_o.saturate = op_i inside {simd_pkg::OP_KADD8,  simd_pkg::OP_KADD16,
                                   simd_pkg::OP_UKADD8, simd_pkg::OP_UKADD16,
                                   simd_pkg::OP_KSUB8,  simd_pkg::OP_KSUB16,
                                   simd_pkg::OP_UKSUB8, simd_pkg::OP_UKSUB16};

    ctrl_o.shift_left = op_i inside {simd_pkg::OP_SLL8,  simd_pkg::OP_SLL16,
                                     simd_pkg::OP_SLLI8, simd_pkg::OP_SLLI16};
    ctrl_o.shift_arith = op_i inside {simd_pkg::OP_SRA8,  simd_pkg::OP_SRA16,
                                      simd_pkg::OP_SRAI8, simd_pkg::OP_SRAI16};
    ctrl_o.use_imm = op_i inside {simd_pkg::OP_SRAI8, simd_pkg::OP_SRAI16,
                                  simd_pkg::OP_SRLI8, simd_pkg::OP_SRLI16,
                                  simd_pkg::OP_SLLI8, simd_pkg::OP_SLLI16};

    unique case (op_i)
      simd_pkg::OP_SCMPLT8, simd_pkg::OP_SCMPLT16,
      simd_pkg::OP_UCMPLT8, simd_pkg::OP_UCMPLT16: ctrl_o.cmp = simd_pkg::CMP_LT;
      simd_pkg::OP_SCMPLE8, simd_pkg::OP_SCMPLE16,
      simd_pkg::OP_UCMPLE8, simd_pkg::OP_UCMPLE16: ctrl_o.cmp = simd_pkg::CMP_LE;
      simd_pkg::OP_SMIN8,   simd_pkg::OP_SMIN16,
      simd_pkg::OP_UMIN8,   simd_pkg::OP_UMIN16:   ctrl_o.cmp = simd_pkg::CMP_MIN;
      simd_pkg::OP_SMAX8,   simd_pkg::OP_SMAX16,
      simd_pkg::OP_UMAX8,   simd_pkg::OP_UMAX16:   ctrl_o.cmp = simd_pkg::CMP_MAX;
      default:                                     ctrl_o.cmp = simd_pkg::CMP_EQ;
    endcase
  end

  // A presented opcode must select one of the five result sources
  always_comb begin
    if (!$isunknown(op_i)) begin
      assert (ctrl_o.unit inside {simd_pkg::UNIT_ADDER, simd_pkg::UNIT_COMPARE,
                                  simd_pkg::UNIT_MINMAX, simd_pkg::UNIT_SHIFT,
                                  simd_pkg::UNIT_PERMUTE})
        else $error("simd_decode: opcode %0d selects no unit", op_i);
    end
  end

endmodule

//--- src/simd_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the packed-SIMD ALU
// The decoder depends on the opcode order below. Groups are contiguous
// and every 8/16 pair sits on an even/odd code
//////////////////////////////////////////////////////////////////////
package simd_pkg;

  localparam int XLEN = 32;

  typedef enum logic [6:0] {
    // Adder ops
    OP_ADD8,      OP_ADD16,     OP_SUB8,      OP_SUB16,
    OP_RADD8,     OP_RADD16,    OP_URADD8,    OP_URADD16,
    OP_RSUB8,     OP_RSUB16,    OP_URSUB8,    OP_URSUB16,
    OP_KADD8,     OP_KADD16,    OP_UKADD8,    OP_UKADD16,
    OP_KSUB8,     OP_KSUB16,    OP_UKSUB8,    OP_UKSUB16,
    // Compares
    OP_CMPEQ8,    OP_CMPEQ16,   OP_SCMPLT8,   OP_SCMPLT16,
    OP_SCMPLE8,   OP_SCMPLE16,  OP_UCMPLT8,   OP_UCMPLT16,
    OP_UCMPLE8,   OP_UCMPLE16,
    // Min and max
    OP_SMIN8,     OP_SMIN16,    OP_SMAX8,     OP_SMAX16,
    OP_UMIN8,     OP_UMIN16,    OP_UMAX8,     OP_UMAX16,
    // Shifts
    OP_SRA8,      OP_SRA16,     OP_SRL8,      OP_SRL16,
    OP_SLL8,      OP_SLL16,     OP_SRAI8,     OP_SRAI16,
    OP_SRLI8,     OP_SRLI16,    OP_SLLI8,     OP_SLLI16,
    // Unpack, pack, insert byte
    OP_SUNPKD810, OP_SUNPKD820, OP_SUNPKD830, OP_SUNPKD831, OP_SUNPKD832,
    OP_ZUNPKD810, OP_ZUNPKD820, OP_ZUNPKD830, OP_ZUNPKD831, OP_ZUNPKD832,
    OP_PKBB16,    OP_PKBT16,    OP_PKTB16,    OP_PKTT16,
    OP_INSB0,     OP_INSB1,     OP_INSB2,     OP_INSB3
  } simd_op_e;

  typedef enum logic [2:0] {
    UNIT_ADDER,
    UNIT_COMPARE,
    UNIT_MINMAX,
    UNIT_SHIFT,
    UNIT_PERMUTE
  } simd_unit_e;

  typedef enum logic {
    W8,
    W16
  } simd_width_e;

  typedef enum logic [2:0] {
    CMP_EQ,
    CMP_LT,
    CMP_LE,
    CMP_MIN,
    CMP_MAX
  } simd_cmp_e;

  typedef struct packed {
    simd_op_e        op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] rd;   // Only read by insert byte
    logic [4:0]      imm;
  } simd_req_t;

  typedef struct packed {
    simd_unit_e  unit;
    simd_width_e width;
    logic        is_signed;
    simd_cmp_e   cmp;
    logic        sub;          // Invert b, carry in one at each lane start
    logic        halve;
    logic        saturate;
    logic        shift_left;
    logic        shift_arith;
    logic        use_imm;
  } simd_ctrl_t;

  // Byte slices of the adder, carry out in bit 8
  typedef struct packed {
    logic [3:0][8:0] lane;
  } simd_lane_sum_t;

endpackage
